// File: rtl/beamformer_pkg.sv
// beamformer package, shared widths, channel count and sample types for the datapath
package beamformer_pkg;

    // number of antenna channels summed into one output beam
    localparam int NUM_CHANNELS = 4;

    // width of the real or the imaginary part of one sample
    localparam int SAMPLE_WIDTH = 16;

    // width of the real or the imaginary part of one weight
    localparam int WEIGHT_WIDTH = 8;

    // a full product of a sample part and a weight part needs both widths together
    localparam int PART_WIDTH = SAMPLE_WIDTH + WEIGHT_WIDTH;

    // enough bits to index every channel
    localparam int CHAN_SEL_WIDTH = 2;

    // one signed sample part, two's complement
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // one signed weight part
    // the weight is a fraction, so its value is the raw integer divided by 256
    // a raw value of 64 therefore scales by one quarter
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // channel index used when a weight is written
    typedef logic [CHAN_SEL_WIDTH-1:0] chan_sel_t;

endpackage

// File: rtl/weight_regs.sv
// weight register block, holds the complex weight of each channel and updates it on a write strobe
module weight_regs (
    input  logic                                                        clock,
    input  logic                                                        resetn,
    input  logic                                                        weight_wr,
    input  beamformer_pkg::chan_sel_t                                   weight_sel,
    input  beamformer_pkg::weight_t                                     weight_re,
    input  beamformer_pkg::weight_t                                     weight_im,
    output beamformer_pkg::weight_t [beamformer_pkg::NUM_CHANNELS-1:0]  chan_weight_re,
    output beamformer_pkg::weight_t [beamformer_pkg::NUM_CHANNELS-1:0]  chan_weight_im
);
    import beamformer_pkg::*;

    // one write enable per channel, decoded from the strobe and the index
    logic [NUM_CHANNELS-1:0] chan_wr;

    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            chan_wr[c] = weight_wr && (weight_sel == chan_sel_t'(c));
        end
    end

    // eight weight registers, two per channel
    // every weight reads zero after reset, so an unprogrammed channel adds nothing to the beam
    always_ff @(posedge clock) begin
        if (!resetn) begin
            chan_weight_re <= '0;
            chan_weight_im <= '0;
        end else begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                // the real and imaginary parts always change together
                if (chan_wr[c]) begin
                    chan_weight_re[c] <= weight_re;
                    chan_weight_im[c] <= weight_im;
                end
            end
        end
    end

endmodule

// File: rtl/complex_weighter.sv
// complex weighter, three-stage multiply and scale of every lane of one channel by its weight
module complex_weighter #(
    parameter int LANES = 8
) (
    input  logic                                    clock,
    input  logic                                    resetn,
    input  logic                                    advance,
    input  logic                                    in_valid,
    input  logic                                    in_last,
    input  beamformer_pkg::sample_t [LANES-1:0]     in_re,
    input  beamformer_pkg::sample_t [LANES-1:0]     in_im,
    input  beamformer_pkg::weight_t                 weight_re,
    input  beamformer_pkg::weight_t                 weight_im,
    output logic                                    wt_valid,
    output logic                                    wt_last,
    output beamformer_pkg::sample_t [LANES-1:0]     wt_re,
    output beamformer_pkg::sample_t [LANES-1:0]     wt_im
);
    import beamformer_pkg::*;

    // the sum or difference of two scaled products needs one extra bit before halving
    localparam int DIFF_WIDTH = SAMPLE_WIDTH + 1;

    // stage one holds the accepted beat
    logic                   s1_valid;
    logic                   s1_last;
    sample_t [LANES-1:0]    s1_re;
    sample_t [LANES-1:0]    s1_im;

    // stage two holds the four full products of every lane
    logic                           s2_valid;
    logic                           s2_last;
    logic signed [PART_WIDTH-1:0]   prod_rr [LANES];
    logic signed [PART_WIDTH-1:0]   prod_ii [LANES];
    logic signed [PART_WIDTH-1:0]   prod_ri [LANES];
    logic signed [PART_WIDTH-1:0]   prod_ir [LANES];

    // stage three result before it is registered
    sample_t [LANES-1:0]    next_re;
    sample_t [LANES-1:0]    next_im;

    // valid and last travel beside the data and never look at it
    // a slot only loads while advance is high, so stage one valid is in_valid and advance
    always_ff @(posedge clock) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            s2_valid <= 1'b0;
            s2_last  <= 1'b0;
            wt_valid <= 1'b0;
            wt_last  <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
            s1_last  <= in_last;
            s2_valid <= s1_valid;
            s2_last  <= s1_last;
            wt_valid <= s2_valid;
            wt_last  <= s2_last;
        end
    end

    // data stages, all held together while the pipeline is stalled
    always_ff @(posedge clock) begin
        if (advance) begin
            s1_re <= in_re;
            s1_im <= in_im;
            // both operands are sign extended to the product width before multiplying
            // the weight is sampled here, so a new weight applies from the next beat to arrive
            for (int l = 0; l < LANES; l++) begin
                prod_rr[l] <= PART_WIDTH'(s1_re[l]) * PART_WIDTH'(weight_re);
                prod_ii[l] <= PART_WIDTH'(s1_im[l]) * PART_WIDTH'(weight_im);
                prod_ri[l] <= PART_WIDTH'(s1_re[l]) * PART_WIDTH'(weight_im);
                prod_ir[l] <= PART_WIDTH'(s1_im[l]) * PART_WIDTH'(weight_re);
            end
            wt_re <= next_re;
            wt_im <= next_im;
        end
    end

    // dropping the low weight bits of a product is its floor divided by 256
    // real part is (rr - ii) / 2 and imaginary part is (ri + ir) / 2, both rounded down
    always_comb begin
        sample_t                        rr;
        sample_t                        ii;
        sample_t                        ri;
        sample_t                        ir;
        logic signed [DIFF_WIDTH-1:0]   re_diff;
        logic signed [DIFF_WIDTH-1:0]   im_sum;
        for (int l = 0; l < LANES; l++) begin
            rr = sample_t'(prod_rr[l][PART_WIDTH-1:WEIGHT_WIDTH]);
            ii = sample_t'(prod_ii[l][PART_WIDTH-1:WEIGHT_WIDTH]);
            ri = sample_t'(prod_ri[l][PART_WIDTH-1:WEIGHT_WIDTH]);
            ir = sample_t'(prod_ir[l][PART_WIDTH-1:WEIGHT_WIDTH]);
            re_diff = DIFF_WIDTH'(rr) - DIFF_WIDTH'(ii);
            im_sum  = DIFF_WIDTH'(ri) + DIFF_WIDTH'(ir);
            // the halved value always fits back into one sample part
            next_re[l] = sample_t'(re_diff[DIFF_WIDTH-1:1]);
            next_im[l] = sample_t'(im_sum[DIFF_WIDTH-1:1]);
        end
    end

    // a stall from the combiner freezes this weighter's output slot
    assert property (@(posedge clock) disable iff (!resetn)
        !advance |=> $stable(wt_valid));

endmodule

// File: rtl/channel_combiner.sv
// channel combiner, two-stage lane-wise sum of the four weighted channels and the stall control
module channel_combiner #(
    parameter int LANES = 8
) (
    input  logic                                                                    clock,
    input  logic                                                                    resetn,
    input  logic                                                                    out_ready,
    input  logic [beamformer_pkg::NUM_CHANNELS-1:0]                                 wt_valid,
    input  logic                                                                    wt_last,
    input  beamformer_pkg::sample_t [beamformer_pkg::NUM_CHANNELS-1:0][LANES-1:0]   wt_re,
    input  beamformer_pkg::sample_t [beamformer_pkg::NUM_CHANNELS-1:0][LANES-1:0]   wt_im,
    output logic                                                                    advance,
    output logic                                                                    out_valid,
    output logic                                                                    out_last,
    output beamformer_pkg::sample_t [LANES-1:0]                                     out_re,
    output beamformer_pkg::sample_t [LANES-1:0]                                     out_im
);
    import beamformer_pkg::*;

    // a pair sum needs one bit more than a sample, the sum of four needs two
    localparam int PAIR_WIDTH  = SAMPLE_WIDTH + 1;
    localparam int TOTAL_WIDTH = SAMPLE_WIDTH + 2;

    // set on the first cycle out of reset and held from then on
    logic run;

    // first stage, the pairwise sums of channels 0 and 1 and of channels 2 and 3
    logic                           c1_valid;
    logic                           c1_last;
    logic signed [PAIR_WIDTH-1:0]   pair_lo_re [LANES];
    logic signed [PAIR_WIDTH-1:0]   pair_hi_re [LANES];
    logic signed [PAIR_WIDTH-1:0]   pair_lo_im [LANES];
    logic signed [PAIR_WIDTH-1:0]   pair_hi_im [LANES];

    // full four-channel sum ahead of the output register
    logic signed [TOTAL_WIDTH-1:0]  total_re [LANES];
    logic signed [TOTAL_WIDTH-1:0]  total_im [LANES];

    always_ff @(posedge clock) begin
        if (!resetn) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // one level stalls every stage in the design, and the source sees it as in_ready
    assign advance = out_ready && run;

    // the channels leave their weighters together, so any bit stands for all of them
    always_ff @(posedge clock) begin
        if (!resetn) begin
            c1_valid  <= 1'b0;
            c1_last   <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            out_re    <= '0;
            out_im    <= '0;
        end else if (advance) begin
            c1_valid  <= &wt_valid;
            c1_last   <= wt_last;
            out_valid <= c1_valid;
            out_last  <= c1_last;
            // dropping the two low bits of the total divides it by four, rounded down
            for (int l = 0; l < LANES; l++) begin
                out_re[l] <= sample_t'(total_re[l][TOTAL_WIDTH-1:2]);
                out_im[l] <= sample_t'(total_im[l][TOTAL_WIDTH-1:2]);
            end
        end
    end

    // pairwise sums, sign extended first so no sum can overflow
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int l = 0; l < LANES; l++) begin
                pair_lo_re[l] <= PAIR_WIDTH'(wt_re[0][l]) + PAIR_WIDTH'(wt_re[1][l]);
                pair_hi_re[l] <= PAIR_WIDTH'(wt_re[2][l]) + PAIR_WIDTH'(wt_re[3][l]);
                pair_lo_im[l] <= PAIR_WIDTH'(wt_im[0][l]) + PAIR_WIDTH'(wt_im[1][l]);
                pair_hi_im[l] <= PAIR_WIDTH'(wt_im[2][l]) + PAIR_WIDTH'(wt_im[3][l]);
            end
        end
    end

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            total_re[l] = TOTAL_WIDTH'(pair_lo_re[l]) + TOTAL_WIDTH'(pair_hi_re[l]);
            total_im[l] = TOTAL_WIDTH'(pair_lo_im[l]) + TOTAL_WIDTH'(pair_hi_im[l]);
        end
    end

    // all four weighters run off the same advance, so their valid pipes must line up
    assert property (@(posedge clock) disable iff (!resetn)
        (&wt_valid) == (|wt_valid));

    // nothing new may reach the output while the sink holds it off
    assert property (@(posedge clock) disable iff (!resetn)
        !advance |=> !$rose(out_valid));

endmodule

// File: rtl/beamformer_top.sv
// beamformer top level, weights four complex channels and sums them into one output beam
module beamformer_top #(
    parameter int LANES = 8
) (
    input  logic                                                                    clock,
    input  logic                                                                    resetn,
    input  logic                                                                    weight_wr,
    input  beamformer_pkg::chan_sel_t                                               weight_sel,
    input  beamformer_pkg::weight_t                                                 weight_re,
    input  beamformer_pkg::weight_t                                                 weight_im,
    input  logic                                                                    in_valid,
    input  logic                                                                    in_last,
    input  beamformer_pkg::sample_t [beamformer_pkg::NUM_CHANNELS-1:0][LANES-1:0]   in_re,
    input  beamformer_pkg::sample_t [beamformer_pkg::NUM_CHANNELS-1:0][LANES-1:0]   in_im,
    output logic                                                                    in_ready,
    output logic                                                                    out_valid,
    output logic                                                                    out_last,
    output beamformer_pkg::sample_t [LANES-1:0]                                     out_re,
    output beamformer_pkg::sample_t [LANES-1:0]                                     out_im,
    input  logic                                                                    out_ready
);
    import beamformer_pkg::*;

    // current weight of every channel
    weight_t [NUM_CHANNELS-1:0] chan_weight_re;
    weight_t [NUM_CHANNELS-1:0] chan_weight_im;

    // common stall level, driven by the combiner
    logic advance;

    // weighted channels on their way to the combiner
    logic [NUM_CHANNELS-1:0]                chan_valid;
    logic                                   lead_last;
    sample_t [NUM_CHANNELS-1:0][LANES-1:0]  chan_re;
    sample_t [NUM_CHANNELS-1:0][LANES-1:0]  chan_im;

    // a beat is taken whenever the pipeline moves
    assign in_ready = advance;

    weight_regs u_weight_regs (
        .clock          (clock),
        .resetn         (resetn),
        .weight_wr      (weight_wr),
        .weight_sel     (weight_sel),
        .weight_re      (weight_re),
        .weight_im      (weight_im),
        .chan_weight_re (chan_weight_re),
        .chan_weight_im (chan_weight_im)
    );

    // one weighter per channel, all sharing the beat's valid and last
    // only channel 0 forwards last, the others carry the same flag and drop it
    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        complex_weighter #(
            .LANES (LANES)
        ) u_complex_weighter (
            .clock     (clock),
            .resetn    (resetn),
            .advance   (advance),
            .in_valid  (in_valid),
            .in_last   (in_last),
            .in_re     (in_re[g]),
            .in_im     (in_im[g]),
            .weight_re (chan_weight_re[g]),
            .weight_im (chan_weight_im[g]),
            .wt_valid  (chan_valid[g]),
            .wt_last   (),
            .wt_re     (chan_re[g]),
            .wt_im     (chan_im[g])
        );
    end

    // channel 0 has its own last connection so the flag has a single source
    assign lead_last = g_chan[0].u_complex_weighter.wt_last;

    channel_combiner #(
        .LANES (LANES)
    ) u_channel_combiner (
        .clock     (clock),
        .resetn    (resetn),
        .out_ready (out_ready),
        .wt_valid  (chan_valid),
        .wt_last   (lead_last),
        .wt_re     (chan_re),
        .wt_im     (chan_im),
        .advance   (advance),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_re    (out_re),
        .out_im    (out_im)
    );

endmodule

// File: verif/tb_beamformer.sv
// testbench for the four-channel beamformer, directed tests checked against a floor-division model
module tb_beamformer;
    import beamformer_pkg::*;

    localparam int LANES = 8;
    // the six tests take about 300 cycles together and the limit allows twice that
    localparam int TEST_CYCLES    = 300;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
    // five register stages, the first of them loads on the accepting edge
    localparam int LATENCY_EDGES  = 4;

    typedef sample_t [LANES-1:0] lanes_t;
    typedef sample_t [NUM_CHANNELS-1:0][LANES-1:0] chan_lanes_t;

    logic           clock;
    logic           resetn;
    logic           weight_wr;
    chan_sel_t      weight_sel;
    weight_t        weight_re;
    weight_t        weight_im;
    logic           in_valid;
    logic           in_last;
    chan_lanes_t    in_re;
    chan_lanes_t    in_im;
    logic           in_ready;
    logic           out_valid;
    logic           out_last;
    lanes_t         out_re;
    lanes_t         out_im;
    logic           out_ready;

    // copy of the weights as last written, used by the model
    weight_t    w_re [NUM_CHANNELS];
    weight_t    w_im [NUM_CHANNELS];

    // expected beats in the order they were accepted
    lanes_t     exp_re_q [$];
    lanes_t     exp_im_q [$];
    logic       exp_last_q [$];

    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    bit         stall_en;

    // output seen while the sink held it off, it must still be there a cycle later
    bit         held_pending;
    logic       held_last;
    lanes_t     held_re;
    lanes_t     held_im;

    beamformer_top #(
        .LANES (LANES)
    ) u_beamformer_top (
        .clock      (clock),
        .resetn     (resetn),
        .weight_wr  (weight_wr),
        .weight_sel (weight_sel),
        .weight_re  (weight_re),
        .weight_im  (weight_im),
        .in_valid   (in_valid),
        .in_last    (in_last),
        .in_re      (in_re),
        .in_im      (in_im),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_re     (out_re),
        .out_im     (out_im),
        .out_ready  (out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at time %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at time %0t: %s expected %b, actual %b",
                     $time, name, expected, actual);
        end
    endtask

    // floor division, since the language division truncates toward zero
    function automatic int floor_div(input int num, input int den);
        int q;
        q = num / den;
        if ((num % den != 0) && ((num < 0) != (den < 0))) begin
            q = q - 1;
        end
        return q;
    endfunction

    // each channel is (rr - ii) / 2 and (ri + ir) / 2, the beam is the lane sum over four
    function automatic void model_beat(input chan_lanes_t s_re, input chan_lanes_t s_im,
                                       output lanes_t e_re, output lanes_t e_im);
        sample_t    sr;
        sample_t    si;
        int         a;
        int         b;
        int         sum_re;
        int         sum_im;
        for (int l = 0; l < LANES; l++) begin
            sum_re = 0;
            sum_im = 0;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                sr = s_re[c][l];
                si = s_im[c][l];
                a = w_re[c];
                b = w_im[c];
                sum_re += floor_div(floor_div(sr * a, 256) - floor_div(si * b, 256), 2);
                sum_im += floor_div(floor_div(sr * b, 256) + floor_div(si * a, 256), 2);
            end
            e_re[l] = sample_t'(floor_div(sum_re, 4));
            e_im[l] = sample_t'(floor_div(sum_im, 4));
        end
    endfunction

    function automatic weight_t random_weight();
        // kept inside -127..127 so that negating a weight cannot overflow
        return weight_t'(int'($urandom_range(0, 254)) - 127);
    endfunction

    function automatic void random_beat(output chan_lanes_t s_re, output chan_lanes_t s_im);
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            for (int l = 0; l < LANES; l++) begin
                s_re[c][l] = sample_t'($urandom);
                s_im[c][l] = sample_t'($urandom);
            end
        end
    endfunction

    task automatic step();
        @(posedge clock);
        #2;
    endtask

    // each write is followed by an idle cycle with the index left in place
    task automatic write_weight(input chan_sel_t sel, input weight_t re, input weight_t im);
        weight_wr  = 1'b1;
        weight_sel = sel;
        weight_re  = re;
        weight_im  = im;
        step();
        weight_wr = 1'b0;
        w_re[sel] = re;
        w_im[sel] = im;
        step();
    endtask

    // holds the beat until an edge sees in_ready, then queues what the model expects
    task automatic send_beat(input chan_lanes_t s_re, input chan_lanes_t s_im, input logic last);
        logic   taken;
        lanes_t e_re;
        lanes_t e_im;
        in_valid = 1'b1;
        in_last  = last;
        in_re    = s_re;
        in_im    = s_im;
        taken    = 1'b0;
        while (!taken) begin
            if (stall_en) begin
                out_ready = ($urandom_range(0, 2) != 0);
            end
            @(negedge clock);
            taken = in_ready;
            step();
        end
        model_beat(s_re, s_im, e_re, e_im);
        exp_re_q.push_back(e_re);
        exp_im_q.push_back(e_im);
        exp_last_q.push_back(last);
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic send_burst(input int beats, input int last_every);
        chan_lanes_t s_re;
        chan_lanes_t s_im;
        for (int k = 0; k < beats; k++) begin
            random_beat(s_re, s_im);
            send_beat(s_re, s_im, (last_every > 0) && (k % last_every == last_every - 1));
        end
    endtask

    task automatic wait_drain();
        while (exp_re_q.size() != 0) begin
            step();
        end
        // a few idle cycles catch a beat that comes out twice
        repeat (3) begin
            step();
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // transfers happen on edges where out_valid and out_ready are both high
    always @(negedge clock) begin : monitor
        lanes_t e_re;
        lanes_t e_im;
        logic   e_last;
        if (resetn) begin
            if (held_pending) begin
                check_flag("out_valid", 1'b1, out_valid);
                check_flag("out_last", held_last, out_last);
                for (int l = 0; l < LANES; l++) begin
                    check_sample($sformatf("out_re[%0d]", l), held_re[l], out_re[l]);
                    check_sample($sformatf("out_im[%0d]", l), held_im[l], out_im[l]);
                end
            end
            if (out_valid && out_ready) begin
                if (exp_re_q.size() == 0) begin
                    error_count++;
                    $display("an output beat arrived at time %0t with no beat expected", $time);
                end else begin
                    e_re   = exp_re_q.pop_front();
                    e_im   = exp_im_q.pop_front();
                    e_last = exp_last_q.pop_front();
                    check_flag("out_last", e_last, out_last);
                    for (int l = 0; l < LANES; l++) begin
                        check_sample($sformatf("out_re[%0d]", l), e_re[l], out_re[l]);
                        check_sample($sformatf("out_im[%0d]", l), e_im[l], out_im[l]);
                    end
                end
            end
            held_pending = out_valid && !out_ready;
            held_last    = out_last;
            held_re      = out_re;
            held_im      = out_im;
        end
    end

    task automatic test_reset();
        int errors_before;
        errors_before = error_count;
        check_flag("in_ready", 1'b0, in_ready);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("out_last", 1'b0, out_last);
        for (int l = 0; l < LANES; l++) begin
            check_sample($sformatf("out_re[%0d]", l), '0, out_re[l]);
            check_sample($sformatf("out_im[%0d]", l), '0, out_im[l]);
        end
        resetn = 1'b1;
        // the run flag sets on the first edge after release, so in_ready lags by one cycle
        @(negedge clock);
        check_flag("in_ready", 1'b0, in_ready);
        @(negedge clock);
        check_flag("in_ready", 1'b1, in_ready);
        step();
        report_test("test 1 reset values", errors_before);
    endtask

    task automatic test_single_beat();
        int             errors_before;
        int             edges;
        chan_lanes_t    s_re;
        chan_lanes_t    s_im;
        errors_before = error_count;
        write_weight(2'd0, 8'sd64, 8'sd0);
        for (int c = 1; c < NUM_CHANNELS; c++) begin
            write_weight(chan_sel_t'(c), '0, '0);
        end
        random_beat(s_re, s_im);
        send_beat(s_re, s_im, 1'b0);
        edges = 0;
        @(negedge clock);
        while (!out_valid && edges < 20) begin
            @(negedge clock);
            edges++;
        end
        if (edges != LATENCY_EDGES) begin
            error_count++;
            $display("the beat came out %0d edges after the accepting edge instead of %0d",
                     edges, LATENCY_EDGES);
        end
        wait_drain();
        report_test("test 2 single beat with a real weight", errors_before);
    endtask

    task automatic test_burst();
        int errors_before;
        errors_before = error_count;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            write_weight(chan_sel_t'(c), random_weight(), random_weight());
        end
        fork
            send_burst(30, 0);
            begin
                // once the first beat is out, one more must follow on every cycle
                @(negedge clock);
                while (!out_valid) begin
                    @(negedge clock);
                end
                for (int k = 1; k < 30; k++) begin
                    @(negedge clock);
                    check_flag("out_valid", 1'b1, out_valid);
                end
            end
        join
        wait_drain();
        report_test("test 3 back-to-back burst", errors_before);
    endtask

    task automatic test_backpressure();
        int errors_before;
        errors_before = error_count;
        stall_en = 1'b1;
        send_burst(40, 0);
        stall_en  = 1'b0;
        out_ready = 1'b1;
        wait_drain();
        report_test("test 4 back-pressure", errors_before);
    endtask

    task automatic test_last();
        int errors_before;
        errors_before = error_count;
        send_burst(20, 5);
        wait_drain();
        report_test("test 5 last flag", errors_before);
    endtask

    task automatic test_rewrite();
        int errors_before;
        errors_before = error_count;
        write_weight(2'd1, '0, '0);
        write_weight(2'd2, weight_t'(-int'(w_re[2])), weight_t'(-int'(w_im[2])));
        send_burst(12, 0);
        wait_drain();
        report_test("test 6 weight rewrite", errors_before);
    endtask

    initial begin
        void'($urandom(32'he6c5));
        resetn     = 1'b0;
        weight_wr  = 1'b0;
        weight_sel = '0;
        weight_re  = '0;
        weight_im  = '0;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        in_re      = '0;
        in_im      = '0;
        out_ready  = 1'b1;
        stall_en   = 1'b0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            w_re[c] = '0;
            w_im[c] = '0;
        end
        repeat (5) begin
            @(posedge clock);
        end
        #2;
        test_reset();
        test_single_beat();
        test_burst();
        test_backpressure();
        test_last();
        test_rewrite();
        $display("tests run: 6, checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/beamformer_pkg.sv
rtl/weight_regs.sv
rtl/complex_weighter.sv
rtl/channel_combiner.sv
rtl/beamformer_top.sv
verif/tb_beamformer.sv

// File: run_sim.sh
#!/bin/sh
# builds the beamformer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_beamformer -f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_beamformer)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
    exit 0
else
    exit 1
fi
